/* i_cache.f */
source/icache_pkg.sv
source/icache_if.sv
source/bram.sv
source/fetch_queue.sv
source/line_lookup.sv
source/axi_refill.sv
source/resp_sender.sv
source/i_cache.sv
bench/i_cache_chk.sv
bench/tb_i_cache.sv

/* Bender.yml */
package:
  name: i_cache

sources:
  - files:
      - source/icache_pkg.sv
      - source/icache_if.sv
      - source/bram.sv
      - source/fetch_queue.sv
      - source/line_lookup.sv
      - source/axi_refill.sv
      - source/resp_sender.sv
      - source/i_cache.sv
  - target: test
    files:
      - bench/i_cache_chk.sv
      - bench/tb_i_cache.sv

/* bench/tb_i_cache.sv */
`timescale 1ns/1ps

module tb_i_cache
  import icache_pkg::*;
();
  localparam int req_depth  = 4;
  localparam int resp_depth = 4;
  localparam int n_random   = 300;
  localparam int n_repeat   = 60;
  localparam int n_error    = 24;
  localparam int n_fetches  = n_random + req_depth + resp_depth + n_repeat + n_error;
  localparam logic [31:0] data_mask = 32'hA5A5_5A5A;
  // privileged, secure, instruction
  localparam logic [2:0]  expected_prot = 3'b101;
  // six regions of ordinary memory, two that answer with SLVERR
  localparam logic [31:0] region_base [8] = '{
    32'h0000_1000, 32'h0000_1200, 32'h0040_0040, 32'h0001_0080,
    32'h2000_1040, 32'h8000_00C0, 32'hF000_0000, 32'hF800_1200
  };

  logic        clk = 1'b0;
  logic        axi_areset;
  logic        fetch_valid;
  logic [31:0] fetch_addr;
  logic        fetch_credit;
  logic        resp_credit;
  logic        resp_valid;
  logic [31:0] resp_addr;
  logic [31:0] resp_data;
  logic        resp_err;
  logic        arvalid;
  logic        arready;
  logic [31:0] araddr;
  logic [2:0]  arprot;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;

  fetch_addr_t          pool [48];
  fetch_addr_t          expected [$];
  fetch_addr_t          axi_reads [$];
  logic                 model_valid [line_count];
  logic [tag_width-1:0] model_tag [line_count];

  int          errors;
  int          tests;
  int          fetch_credits;
  int          issued;
  int          received;
  int          granted;
  int          credit_pulses;
  int          read_count;
  int          mem_phase;
  int          mem_delay;
  logic [31:0] mem_addr;

  always #4 clk = ~clk;

  i_cache #(
    .req_depth(req_depth),
    .resp_depth(resp_depth)
  ) UUT (.*);

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input fetch_addr_t got,
                            input fetch_addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got.raw, exp.raw);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // compare a response with the oldest outstanding fetch
  task automatic score_response();
    fetch_addr_t exp;
    fetch_addr_t beat_addr;
    logic        hit;
    logic        bad;
    if (expected.size() == 0) begin
      errors++;
      $display("response for %h arrived with no fetch outstanding", resp_addr);
      return;
    end
    exp = expected.pop_front();
    hit = model_valid[exp.fields.index] && model_tag[exp.fields.index] == exp.fields.tag;
    bad = exp.raw >= 32'hF000_0000;
    check_addr("resp_addr", resp_addr, exp);
    check_flag("resp_err", resp_err, bad);
    if (!bad) begin
      check_word("resp_data", resp_data, exp.raw ^ data_mask);
    end
    if (!hit) begin
      // a miss reads the whole line, lowest word first
      for (int b = 0; b < line_words; b++) begin
        beat_addr.raw = {exp.raw[31:4], 4'b0000} + 32'(4 * b);
        if (axi_reads.size() == 0) begin
          errors++;
          $display("miss on %h was not backed by four AXI reads", exp.raw);
          return;
        end
        check_addr("araddr", axi_reads.pop_front(), beat_addr);
      end
      if (!bad) begin
        model_valid[exp.fields.index] = 1'b1;
        model_tag[exp.fields.index]   = exp.fields.tag;
      end
    end
  endtask

  // sample at the edge, drive 1 ns later
  task automatic step_cycle(input bit issue_en, input bit credit_en, input int lo,
                            input int hi);
    logic        ar_done;
    logic        r_done;
    fetch_addr_t pick;
    @(posedge clk);
    ar_done = arvalid && arready;
    r_done  = rvalid && rready;
    if (ar_done) begin
      mem_addr = araddr;
      axi_reads.push_back(araddr);
      read_count++;
      check_word("arprot", 32'(arprot), 32'(expected_prot));
    end
    if (fetch_credit) begin
      fetch_credits++;
      credit_pulses++;
    end
    if (resp_valid) begin
      received++;
      score_response();
    end
    #1;
    // memory model: accept address, wait, hold data until rready
    case (mem_phase)
      0: begin
        if (ar_done) begin
          arready   = 1'b0;
          mem_delay = $urandom_range(0, 4);
          mem_phase = 1;
        end else if (arvalid) begin
          if (mem_delay == 0) begin
            arready = 1'b1;
          end else begin
            mem_delay--;
          end
        end
      end
      1: begin
        if (mem_delay == 0) begin
          rvalid    = 1'b1;
          rdata     = mem_addr ^ data_mask;
          rresp     = (mem_addr >= 32'hF000_0000) ? 2'b10 : 2'b00;
          mem_phase = 2;
        end else begin
          mem_delay--;
        end
      end
      default: begin
        if (r_done) begin
          rvalid    = 1'b0;
          mem_delay = $urandom_range(0, 2);
          mem_phase = 0;
        end
      end
    endcase
    fetch_valid = 1'b0;
    if (issue_en && fetch_credits > 0 && $urandom_range(0, 3) != 0) begin
      pick        = pool[$urandom_range(lo, hi)];
      fetch_valid = 1'b1;
      fetch_addr  = pick.raw;
      fetch_credits--;
      issued++;
      expected.push_back(pick);
    end
    // never bank more credits than responses still owed
    resp_credit = 1'b0;
    if (credit_en && granted - received < expected.size() && $urandom_range(0, 2) != 0) begin
      resp_credit = 1'b1;
      granted++;
    end
  endtask

  task automatic drain();
    while (expected.size() != 0) begin
      step_cycle(1'b0, 1'b1, 0, 0);
    end
  endtask

  task automatic run_fetches(input int count, input int lo, input int hi);
    int target;
    target = issued + count;
    while (issued < target) begin
      step_cycle(1'b1, 1'b1, lo, hi);
    end
    drain();
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin : main
    int start_errors;
    int start_issued;
    int start_received;
    int start_reads;
    void'($urandom(33254));
    axi_areset    = 1'b1;
    fetch_valid   = 1'b0;
    fetch_addr    = '0;
    resp_credit   = 1'b0;
    arready       = 1'b0;
    rvalid        = 1'b0;
    rdata         = '0;
    rresp         = 2'b00;
    errors        = 0;
    tests         = 0;
    fetch_credits = req_depth;
    issued        = 0;
    received      = 0;
    granted       = 0;
    credit_pulses = 0;
    read_count    = 0;
    mem_phase     = 0;
    mem_delay     = 0;
    mem_addr      = '0;
    // six word addresses per region, spread over four lines
    for (int r = 0; r < 8; r++) begin
      for (int j = 0; j < 6; j++) begin
        pool[6*r+j].raw = region_base[r] + 32'($urandom_range(0, 15) * 4);
      end
    end
    for (int i = 0; i < line_count; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    repeat (3) @(posedge clk);
    #1 axi_areset = 1'b0;

    start_errors = errors;
    run_fetches(n_random, 0, 47);
    report_test("random traffic", start_errors);

    start_errors   = errors;
    start_issued   = issued;
    start_received = received;
    repeat (400) step_cycle(1'b1, 1'b0, 0, 47);
    if (received != start_received) begin
      errors++;
      $display("responses were sent while consumer credits were withheld");
    end
    if (issued - start_issued > req_depth + resp_depth) begin
      errors++;
      $display("fetch credits kept coming, %0d fetches taken while stalled",
               issued - start_issued);
    end
    drain();
    report_test("back-pressure", start_errors);

    start_errors = errors;
    start_reads  = read_count;
    run_fetches(n_repeat, 0, 5);
    if (read_count - start_reads > 4 * line_words) begin
      errors++;
      $display("repeated fetches to one region caused %0d AXI reads", read_count - start_reads);
    end
    report_test("repeat hits", start_errors);

    start_errors = errors;
    start_reads  = read_count;
    run_fetches(n_error, 36, 47);
    check_word("AXI read count", 32'(read_count - start_reads), 32'(n_error * line_words));
    report_test("error region", start_errors);

    start_errors = errors;
    repeat (4) step_cycle(1'b0, 1'b0, 0, 0);
    check_word("fetch_credit pulses", 32'(credit_pulses), 32'(issued));
    if (axi_reads.size() != 0) begin
      errors++;
      $display("%0d AXI reads were not explained by any miss", axi_reads.size());
    end
    report_test("credit counts", start_errors);

    errors += UUT.chk.fails;
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // 200 cycles per fetch
  initial begin : watchdog
    #(n_fetches * 200 * 8);
    $display("watchdog expired before all tests finished");
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* bench/i_cache_chk.sv */
`timescale 1ns/1ps

module i_cache_chk (
  input logic        clk,
  input logic        axi_areset,
  input logic        arvalid,
  input logic        arready,
  input logic [31:0] araddr,
  input logic        resp_credit,
  input logic        resp_valid
);
  // consumer credits granted and not yet spent
  int banked;
  int fails = 0;

  always_ff @(posedge clk) begin
    if (axi_areset) begin
      banked <= 0;
    end else begin
      banked <= banked + int'(resp_credit) - int'(resp_valid);
    end
  end

  ar_stable: assert property (@(posedge clk) disable iff (axi_areset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      $error("arvalid dropped or araddr moved before arready");
      fails++;
    end

  ar_aligned: assert property (@(posedge clk) disable iff (axi_areset)
    arvalid |-> araddr[1:0] == 2'b00)
    else begin
      $error("araddr is not word aligned");
      fails++;
    end

  resp_within_credit: assert property (@(posedge clk) disable iff (axi_areset)
    resp_valid |-> banked != 0)
    else begin
      $error("resp_valid with no consumer credit left");
      fails++;
    end

endmodule

bind i_cache i_cache_chk chk (.*);

/* source/i_cache.sv */
`timescale 1ns/1ps

module i_cache
  import icache_pkg::*;
#(
  parameter int req_depth  = 4,
  parameter int resp_depth = 4
) (
  input  logic        clk,
  input  logic        axi_areset,
  // fetch unit
  input  logic        fetch_valid,
  input  logic [31:0] fetch_addr,
  output logic        fetch_credit,
  // consumer
  input  logic        resp_credit,
  output logic        resp_valid,
  output logic [31:0] resp_addr,
  output logic [31:0] resp_data,
  output logic        resp_err,
  // axi4-lite read
  output logic        arvalid,
  input  logic        arready,
  output logic [31:0] araddr,
  output logic [2:0]  arprot,
  input  logic        rvalid,
  output logic        rready,
  input  logic [31:0] rdata,
  input  logic [1:0]  rresp
);
  logic        req_valid;
  fetch_addr_t req_addr;
  logic        req_take;

  fetch_resp_if rsp_bus ();
  refill_if     rf_bus ();

  fetch_queue #(
    .req_depth(req_depth)
  ) u_fetch_queue (
    .clk,
    .axi_areset,
    .fetch_valid,
    .fetch_addr,
    .fetch_credit,
    .req_valid,
    .req_addr,
    .req_take
  );

  line_lookup u_line_lookup (
    .clk,
    .axi_areset,
    .req_valid,
    .req_addr,
    .req_take,
    .rsp(rsp_bus.source),
    .rf(rf_bus.client)
  );

  axi_refill u_axi_refill (
    .clk,
    .axi_areset,
    .rf(rf_bus.server),
    .arvalid,
    .arready,
    .araddr,
    .arprot,
    .rvalid,
    .rready,
    .rdata,
    .rresp
  );

  resp_sender #(
    .resp_depth(resp_depth)
  ) u_resp_sender (
    .clk,
    .axi_areset,
    .rsp(rsp_bus.sink),
    .resp_credit,
    .resp_valid,
    .resp_addr,
    .resp_data,
    .resp_err
  );

endmodule

/* source/resp_sender.sv */
`timescale 1ns/1ps

module resp_sender
  import icache_pkg::*;
#(
  parameter int resp_depth = 4
) (
  input  logic        clk,
  input  logic        axi_areset,
  fetch_resp_if.sink  rsp,
  input  logic        resp_credit,
  output logic        resp_valid,
  output logic [31:0] resp_addr,
  output logic [31:0] resp_data,
  output logic        resp_err
);
  localparam int ptr_width    = (resp_depth > 1) ? $clog2(resp_depth) : 1;
  localparam int count_width  = $clog2(resp_depth + 1);
  localparam int credit_width = 16;

  fetch_addr_t             addr_buf [resp_depth];
  logic [31:0]             data_buf [resp_depth];
  logic                    err_buf [resp_depth];
  logic [ptr_width-1:0]    wr_ptr;
  logic [ptr_width-1:0]    rd_ptr;
  logic [count_width-1:0]  count;
  logic [credit_width-1:0] credits;
  logic                    send;

  assign send     = (count != '0) & (credits != '0);
  assign rsp.room = int'(count) + 2 <= resp_depth;

  always_ff @(posedge clk) begin
    if (rsp.valid) begin
      addr_buf[wr_ptr] <= rsp.addr;
      data_buf[wr_ptr] <= rsp.data;
      err_buf[wr_ptr]  <= rsp.err;
    end
    if (send) begin
      resp_addr <= addr_buf[rd_ptr].raw;
      resp_data <= data_buf[rd_ptr];
      resp_err  <= err_buf[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (axi_areset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credits    <= '0;
      resp_valid <= 1'b0;
    end else begin
      if (rsp.valid) begin
        wr_ptr <= (wr_ptr == ptr_width'(resp_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == ptr_width'(resp_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count      <= count + count_width'(rsp.valid) - count_width'(send);
      // each emitted response spends one consumer credit
      credits    <= credits + credit_width'(resp_credit) - credit_width'(send);
      resp_valid <= send;
    end
  end

endmodule

/* source/axi_refill.sv */
`timescale 1ns/1ps

module axi_refill
  import icache_pkg::*;
(
  input  logic        clk,
  input  logic        axi_areset,
  refill_if.server    rf,
  output logic        arvalid,
  input  logic        arready,
  output logic [31:0] araddr,
  output logic [2:0]  arprot,
  input  logic        rvalid,
  output logic        rready,
  input  logic [31:0] rdata,
  input  logic [1:0]  rresp
);
  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_issue   = 2'd1;
  localparam logic [1:0] st_wait    = 2'd2;
  localparam logic [1:0] st_collect = 2'd3;

  logic [1:0]  state;
  logic [1:0]  beat;
  logic [31:0] addr_q;
  line_t       line_q;
  logic        err_q;
  logic        last_beat;

  assign arvalid   = state == st_issue;
  assign rready    = state == st_wait;
  assign araddr    = addr_q;
  assign arprot    = fetch_prot;
  assign last_beat = beat == 2'(line_words - 1);

  assign rf.done = (state == st_collect) & last_beat;
  assign rf.line = line_q;
  assign rf.err  = err_q;

  always_ff @(posedge clk) begin
    if (axi_areset) begin
      state <= st_idle;
      beat  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (rf.start) begin
            state <= st_issue;
            beat  <= '0;
          end
        end
        st_issue: begin
          if (arready) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (rvalid) begin
            state <= st_collect;
          end
        end
        default: begin
          state <= last_beat ? st_idle : st_issue;
          beat  <= beat + 1'b1;
        end
      endcase
    end
  end

  // beats shift in from the top, first word ends up lowest
  always_ff @(posedge clk) begin
    if (state == st_idle && rf.start) begin
      addr_q <= rf.line_addr;
      err_q  <= 1'b0;
    end else if (state == st_wait && rvalid) begin
      line_q <= {rdata, line_q[$bits(line_t)-1:32]};
      err_q  <= err_q | (rresp != 2'b00);
    end else if (state == st_collect) begin
      addr_q <= addr_q + 32'd4;
    end
  end

endmodule

/* source/line_lookup.sv */
`timescale 1ns/1ps

module line_lookup
  import icache_pkg::*;
(
  input  logic         clk,
  input  logic         axi_areset,
  input  logic         req_valid,
  input  fetch_addr_t  req_addr,
  output logic         req_take,
  fetch_resp_if.source rsp,
  refill_if.client     rf
);
  localparam logic [1:0] st_sweep  = 2'd0;
  localparam logic [1:0] st_run    = 2'd1;
  localparam logic [1:0] st_refill = 2'd2;
  localparam logic [1:0] st_replay = 2'd3;

  logic [1:0]             state;
  logic [index_width-1:0] sweep_idx;
  logic                   s2_valid;
  fetch_addr_t            s2_addr;

  logic [index_width-1:0] ram_addr;
  logic                   install;
  logic                   tag_wen;
  tag_entry_t             tag_din;
  line_t                  data_q;
  tag_entry_t             tag_q;
  logic                   hit;

  // stage 1 index source
  always_comb begin
    case (state)
      st_sweep: ram_addr = sweep_idx;
      st_run:   ram_addr = req_addr.fields.index;
      default:  ram_addr = s2_addr.fields.index;
    endcase
  end

  assign install = (state == st_refill) & rf.done & ~rf.err;
  assign tag_wen = install | (state == st_sweep);

  always_comb begin
    tag_din.valid = state != st_sweep;
    tag_din.tag   = s2_addr.fields.tag;
  end

  bram #(
    .data_width($bits(line_t)),
    .depth(line_count)
  ) cached_data (
    .clk,
    .addr(ram_addr),
    .wen(install),
    .din(rf.line),
    .dout(data_q)
  );

  bram #(
    .data_width($bits(tag_entry_t)),
    .depth(line_count)
  ) valid_and_tag (
    .clk,
    .addr(ram_addr),
    .wen(tag_wen),
    .din(tag_din),
    .dout(tag_q)
  );

  // stage 2 compare
  assign hit = s2_valid & tag_q.valid & (tag_q.tag == s2_addr.fields.tag);

  // next request enters while stage 2 is empty or retiring a hit
  assign req_take = (state == st_run) & req_valid & rsp.room & (~s2_valid | hit);

  assign rsp.valid = ((state == st_run) & hit) | ((state == st_refill) & rf.done & rf.err);
  assign rsp.addr  = s2_addr;
  assign rsp.data  = data_q[32*s2_addr.fields.word +: 32];
  assign rsp.err   = state == st_refill;

  assign rf.start     = (state == st_run) & s2_valid & ~hit;
  assign rf.line_addr = {s2_addr.raw[31:4], 4'b0000};

  always_ff @(posedge clk) begin
    if (axi_areset) begin
      state     <= st_sweep;
      sweep_idx <= '0;
      s2_valid  <= 1'b0;
    end else begin
      case (state)
        st_sweep: begin
          sweep_idx <= sweep_idx + 1'b1;
          if (sweep_idx == index_width'(line_count - 1)) begin
            state <= st_run;
          end
        end
        st_run: begin
          if (rf.start) begin
            state <= st_refill;
          end
        end
        st_refill: begin
          // error goes straight out, good line is read back once
          if (rf.done) begin
            state <= rf.err ? st_run : st_replay;
          end
        end
        default: begin
          state <= st_run;
        end
      endcase
      if (req_take) begin
        s2_valid <= 1'b1;
      end else if (rsp.valid) begin
        s2_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_take) begin
      s2_addr <= req_addr;
    end
  end

endmodule

/* source/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue
  import icache_pkg::*;
#(
  parameter int req_depth = 4
) (
  input  logic        clk,
  input  logic        axi_areset,
  input  logic        fetch_valid,
  input  fetch_addr_t fetch_addr,
  output logic        fetch_credit,
  output logic        req_valid,
  output fetch_addr_t req_addr,
  input  logic        req_take
);
  localparam int ptr_width   = (req_depth > 1) ? $clog2(req_depth) : 1;
  localparam int count_width = $clog2(req_depth + 1);

  fetch_addr_t            entries [req_depth];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count;

  assign req_valid = count != '0;
  assign req_addr  = entries[rd_ptr];

  // sender credits guarantee a free slot on every fetch_valid
  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      entries[wr_ptr] <= fetch_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (axi_areset) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      fetch_credit <= 1'b0;
    end else begin
      if (fetch_valid) begin
        wr_ptr <= (wr_ptr == ptr_width'(req_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (req_take) begin
        rd_ptr <= (rd_ptr == ptr_width'(req_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count        <= count + count_width'(fetch_valid) - count_width'(req_take);
      // one credit back per popped entry
      fetch_credit <= req_take;
    end
  end

endmodule

/* source/bram.sv */
`timescale 1ns/1ps

module bram #(
  parameter int data_width = 32,
  parameter int depth      = 32
) (
  input  logic                     clk,
  input  logic [$clog2(depth)-1:0] addr,
  input  logic                     wen,
  input  logic [data_width-1:0]    din,
  output logic [data_width-1:0]    dout
);
  logic [data_width-1:0] mem [depth];

  // registered read, old data on a same-address write
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];
  end

endmodule

/* source/icache_if.sv */
`timescale 1ns/1ps

// lookup to response buffer
interface fetch_resp_if
  import icache_pkg::*;
();
  logic        valid;
  fetch_addr_t addr;
  logic [31:0] data;
  logic        err;
  // at least two free slots
  logic        room;

  modport source (output valid, addr, data, err, input room);
  modport sink (input valid, addr, data, err, output room);
endinterface

// lookup to axi line refill
interface refill_if
  import icache_pkg::*;
();
  logic        start;
  logic [31:0] line_addr;
  logic        done;
  line_t       line;
  logic        err;

  modport client (output start, line_addr, input done, line, err);
  modport server (input start, line_addr, output done, line, err);
endinterface

/* source/icache_pkg.sv */
package icache_pkg;

  // cache geometry, 32 lines of 16 bytes
  localparam int line_words  = 4;
  localparam int line_count  = 32;
  localparam int index_width = 5;
  localparam int tag_width   = 23;

  typedef logic [line_words*32-1:0] line_t;

  // field view of a fetch address
  typedef struct packed {
    logic [tag_width-1:0]   tag;
    logic [index_width-1:0] index;
    logic [1:0]             word;
    logic [1:0]             byte_ofs;
  } addr_fields_t;

  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t fields;
  } fetch_addr_t;

  // tag ram entry
  typedef struct packed {
    logic                 valid;
    logic [tag_width-1:0] tag;
  } tag_entry_t;

  // instruction, secure, privileged
  localparam logic [2:0] fetch_prot = 3'b101;

endpackage
